// ==== project.f ====
+incdir+hw
hw/isaPkg.sv
hw/aluPkg.sv
hw/regFile.sv
hw/instrDecode.sv
hw/aluCore.sv
hw/executeStage.sv
hw/execPipe.sv
test/execChecker.sv
test/execPipeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert --top-module execPipeTb -f project.f \
  -o execPipeSim > build.log 2>&1 ||
  { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/execPipeSim > sim.log 2>&1
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== test/execPipeTb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module execPipeTb;

  localparam int numRows       = 40;
  localparam int resetCycles   = 16;
  localparam int timeoutCycles = numRows + resetCycles + 20;
  localparam int dataW         = `EXEC_DATA_W;

  logic                       clk;
  logic                       rstN;
  logic                       instrValid;
  logic [dataW-1:0]           instr;
  logic [dataW-1:0]           pc;
  logic                       resValid;
  logic [dataW-1:0]           aluResult;
  logic [dataW-1:0]           branchTarget;
  logic [`EXEC_REG_IDX_W-1:0] resDest;
  logic                       zero;
  logic                       ltz;
  logic                       err;

  // Expected row handed to the checker with each instruction
  logic [dataW-1:0]           expResult;
  logic [dataW-1:0]           expTarget;
  logic [`EXEC_REG_IDX_W-1:0] expDest;
  logic [4:0]                 expBits; // chkResult, chkFlags, err, ltz, zero
  int                         errCount;
  int                         pending;
  int                         cycleCount = 0;

  logic [dataW-1:0] instrTab [numRows];
  logic [dataW-1:0] pcTab [numRows];
  logic [dataW-1:0] resTab [numRows];
  logic [dataW-1:0] tgtTab [numRows];
  logic [4:0]       bitTab [numRows];
  logic [dataW-1:0] model [`EXEC_NUM_REGS]; // Architectural register state
  logic [31:0]      rngState = 32'h605862d5;
  int               rowCount = 0;

  // Mix for the random rows, repeats weight the arithmetic
  isaPkg::opcodeE randOps [16] = '{isaPkg::opAnd, isaPkg::opOr, isaPkg::opXor,
    isaPkg::opAndni, isaPkg::opShl, isaPkg::opShr, isaPkg::opAdd, isaPkg::opSub,
    isaPkg::opAddi, isaPkg::opLbi, isaPkg::opAddi, isaPkg::opAdd, isaPkg::opSub,
    isaPkg::opXor, isaPkg::opBr, isaPkg::opMov};

  execPipe DUT (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instr        (instr),
    .pc           (pc),
    .resValid     (resValid),
    .aluResult    (aluResult),
    .branchTarget (branchTarget),
    .resDest      (resDest),
    .zero         (zero),
    .ltz          (ltz),
    .err          (err)
  );

  execChecker uChecker (
    .clk (clk), .rstN (rstN), .resValid (resValid), .aluResult (aluResult),
    .branchTarget (branchTarget), .resDest (resDest), .zero (zero), .ltz (ltz),
    .err (err), .instrValid (instrValid), .expResult (expResult),
    .expTarget (expTarget), .expDest (expDest), .expBits (expBits),
    .errCount (errCount), .pending (pending)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk; // 40 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected outputs straight from the opcode rules, then update the model
  task automatic addRow(input isaPkg::opcodeE op, input logic [2:0] rd, input logic [2:0] rs,
                        input logic [5:0] field6, input logic [dataW-1:0] pcVal);
    logic [dataW-1:0] a;
    logic [dataW-1:0] b;
    logic [dataW-1:0] immV;
    logic [dataW-1:0] res;
    logic [dataW:0]   tgt;
    logic             ofl;
    logic             passThru;
    logic             writes;
    a        = model[rs];
    b        = model[field6[5:3]]; // rt shares bits with the immediate
    immV     = {{(dataW - 6){field6[5]}}, field6};
    ofl      = 1'b0;
    passThru = 1'b0;
    writes   = 1'b1;
    case (op)
      isaPkg::opAdd: begin
        res = a + b;
        ofl = (a[dataW-1] == b[dataW-1]) && (res[dataW-1] != a[dataW-1]);
      end
      isaPkg::opSub: begin
        res = a - b;
        ofl = (a[dataW-1] != b[dataW-1]) && (res[dataW-1] != a[dataW-1]);
      end
      isaPkg::opAnd:   res = a & b;
      isaPkg::opOr:    res = a | b;
      isaPkg::opXor:   res = a ^ b;
      isaPkg::opShl:   res = a << b[3:0];
      isaPkg::opShr:   res = a >> b[3:0];
      isaPkg::opAddi: begin
        res = a + immV;
        ofl = (a[dataW-1] == immV[dataW-1]) && (res[dataW-1] != a[dataW-1]);
      end
      isaPkg::opAndni: res = a & ~immV;
      isaPkg::opLbi: begin
        res      = immV;
        passThru = 1'b1;
      end
      isaPkg::opMov: begin
        res      = a;
        passThru = 1'b1;
        writes   = 1'b0;
      end
      default: begin // Branch, flags of rs + 0
        res    = a;
        writes = 1'b0;
      end
    endcase
    tgt = {1'b0, pcVal} + {1'b0, immV};
    instrTab[rowCount] = {op, rd, rs, field6};
    pcTab[rowCount]    = pcVal;
    resTab[rowCount]   = res;
    tgtTab[rowCount]   = tgt[dataW-1:0];
    bitTab[rowCount]   = {op != isaPkg::opBr, !passThru, !passThru && (ofl || tgt[dataW]),
                          res[dataW-1], res == '0};
    if (writes) model[rd] = res;
    rowCount++;
  endtask

  task automatic buildTable();
    logic [31:0] r;
    logic [31:0] p;
    for (int i = 0; i < `EXEC_NUM_REGS; i++) model[i] = '0;
    addRow(isaPkg::opAdd, 3'd1, 3'd0, 6'o00, 16'h0100); // Fresh registers read zero
    addRow(isaPkg::opBr, 3'd0, 3'd2, 6'o05, 16'h0200);
    addRow(isaPkg::opLbi, 3'd1, 3'd0, 6'o27, 16'hffe0);
    addRow(isaPkg::opLbi, 3'd2, 3'd0, 6'o54, 16'h8000); // Carry out, err stays low
    addRow(isaPkg::opMov, 3'd3, 3'd1, 6'o70, 16'hff00);
    addRow(isaPkg::opLbi, 3'd3, 3'd0, 6'o77, 16'hfff0);
    addRow(isaPkg::opLbi, 3'd4, 3'd0, 6'o01, 16'h0000);
    addRow(isaPkg::opShr, 3'd3, 3'd3, 6'o40, 16'h0010); // 0x7fff via bypass of r4
    addRow(isaPkg::opAdd, 3'd5, 3'd3, 6'o30, 16'h0020); // Signed overflow
    addRow(isaPkg::opLbi, 3'd6, 3'd0, 6'o17, 16'h0030);
    addRow(isaPkg::opShl, 3'd6, 3'd4, 6'o60, 16'h0040); // 0x8000
    addRow(isaPkg::opSub, 3'd7, 3'd6, 6'o40, 16'h0000); // 0x8000 - 1 overflows
    addRow(isaPkg::opAddi, 3'd5, 3'd3, 6'o01, 16'h0004);
    addRow(isaPkg::opSub, 3'd1, 3'd4, 6'o40, 16'h0000); // Zero result
    addRow(isaPkg::opAdd, 3'd2, 3'd6, 6'o60, 16'h0000);
    addRow(isaPkg::opSub, 3'd2, 3'd0, 6'o40, 16'h0000); // Negative, no overflow
    addRow(isaPkg::opBr, 3'd0, 3'd5, 6'o03, 16'h1000);
    addRow(isaPkg::opBr, 3'd0, 3'd7, 6'o74, 16'hfff8); // Target carries out
    addRow(isaPkg::opAddi, 3'd1, 3'd1, 6'o75, 16'h0000);
    addRow(isaPkg::opXor, 3'd2, 3'd1, 6'o40, 16'h0000);
    while (rowCount < numRows) begin
      rngState = xorshift(rngState);
      r        = rngState;
      rngState = xorshift(rngState);
      p        = rngState;
      addRow(randOps[r[19:16]], r[2:0], r[5:3], r[11:6], p[dataW-1:0]);
    end
  endtask

  task automatic printCounts();
    $display("Rows %0d, errors %0d, cycles %0d", numRows, errCount, cycleCount);
  endtask

  initial begin
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    pc         = '0;
    expResult  = '0;
    expTarget  = '0;
    expDest    = '0;
    expBits    = '0;
    buildTable();
    repeat (resetCycles) @(posedge clk);
    #2;
    rstN = 1'b1;
    for (int i = 0; i < numRows; i++) begin // Back to back, one per cycle
      @(posedge clk);
      #2;
      instrValid = 1'b1;
      instr      = instrTab[i];
      pc         = pcTab[i];
      expResult  = resTab[i];
      expTarget  = tgtTab[i];
      expDest    = instrTab[i][isaPkg::rdMsb:isaPkg::rdLsb];
      expBits    = bitTab[i];
    end
    @(posedge clk);
    #2;
    instrValid = 1'b0;
    while (pending != 0) @(posedge clk);
    repeat (4) @(posedge clk); // Room for a stray resValid
    printCounts();
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Run limit from table length plus reset plus drain margin
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycleCount, pending);
      printCounts();
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/execChecker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module execChecker (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       resValid,
  input  logic [`EXEC_DATA_W-1:0]    aluResult,
  input  logic [`EXEC_DATA_W-1:0]    branchTarget,
  input  logic [`EXEC_REG_IDX_W-1:0] resDest,
  input  logic                       zero,
  input  logic                       ltz,
  input  logic                       err,
  input  logic                       instrValid, // Same strobe the DUT samples
  input  logic [`EXEC_DATA_W-1:0]    expResult,
  input  logic [`EXEC_DATA_W-1:0]    expTarget,
  input  logic [`EXEC_REG_IDX_W-1:0] expDest,
  input  logic [4:0]                 expBits, // chkResult, chkFlags, err, ltz, zero
  output int                         errCount,
  output int                         pending
);

  // One entry per instruction in flight, all queues move together
  logic [`EXEC_DATA_W-1:0]    qResult [$];
  logic [`EXEC_DATA_W-1:0]    qTarget [$];
  logic [`EXEC_REG_IDX_W-1:0] qDest [$];
  logic [4:0]                 qBits [$];
  int                         qStamp [$]; // Cycle the instruction was sampled
  int                         cycle = 0;
  int                         errs = 0;
  int                         depth = 0;

  assign errCount = errs;
  assign pending  = depth;

  task automatic checkField(input string name, input logic [`EXEC_DATA_W-1:0] got,
                            input logic [`EXEC_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycle);
      errs++;
    end
  endtask

  // Outputs are settled mid-cycle
  always @(negedge clk) begin
    int                         stamp;
    logic [4:0]                 bits;
    logic [`EXEC_DATA_W-1:0]    expRes;
    logic [`EXEC_DATA_W-1:0]    expTgt;
    logic [`EXEC_REG_IDX_W-1:0] expD;
    cycle++;
    if (resValid === 1'b1) begin
      if (qStamp.size() == 0) begin
        $display("Unexpected resValid with no instruction outstanding at cycle %0d", cycle);
        errs++;
      end else begin
        stamp  = qStamp.pop_front();
        bits   = qBits.pop_front();
        expRes = qResult.pop_front();
        expTgt = qTarget.pop_front();
        expD   = qDest.pop_front();
        if (cycle - stamp != 2) begin // Pipe depth is fixed at two
          $display("resValid came %0d cycles after its instruction instead of 2", cycle - stamp);
          errs++;
        end
        if (bits[4]) checkField("aluResult", aluResult, expRes);
        checkField("branchTarget", branchTarget, expTgt);
        checkField("resDest", 16'(resDest), 16'(expD));
        if (bits[3]) begin // Flags only where the opcode defines them
          checkField("zero", 16'(zero), 16'(bits[0]));
          checkField("ltz", 16'(ltz), 16'(bits[1]));
        end
        checkField("err", 16'(err), 16'(bits[2]));
      end
    end else if (rstN && resValid !== 1'b0) begin
      $display("resValid is unknown at cycle %0d", cycle);
      errs++;
    end
    // Head entry overdue, its result never showed up
    if (qStamp.size() != 0 && cycle - qStamp[0] > 2) begin
      $display("No resValid for the instruction sampled at cycle %0d", qStamp[0]);
      errs++;
      stamp  = qStamp.pop_front();
      bits   = qBits.pop_front();
      expRes = qResult.pop_front();
      expTgt = qTarget.pop_front();
      expD   = qDest.pop_front();
    end
    if (instrValid === 1'b1) begin
      qResult.push_back(expResult);
      qTarget.push_back(expTarget);
      qDest.push_back(expDest);
      qBits.push_back(expBits);
      qStamp.push_back(cycle);
    end
    depth = qStamp.size();
  end

endmodule

`default_nettype wire

// ==== hw/execPipe.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module execPipe (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       instrValid,
  input  logic [`EXEC_DATA_W-1:0]    instr,
  input  logic [`EXEC_DATA_W-1:0]    pc,
  output logic                       resValid,
  output logic [`EXEC_DATA_W-1:0]    aluResult,
  output logic [`EXEC_DATA_W-1:0]    branchTarget,
  output logic [`EXEC_REG_IDX_W-1:0] resDest,
  output logic                       zero,
  output logic                       ltz,
  output logic                       err
);

  // Register file read side
  logic [`EXEC_REG_IDX_W-1:0] rdAddrA;
  logic [`EXEC_REG_IDX_W-1:0] rdAddrB;
  logic [`EXEC_DATA_W-1:0]    rdDataA;
  logic [`EXEC_DATA_W-1:0]    rdDataB;

  // Decode to execute
  logic                       exValid;
  logic [`EXEC_DATA_W-1:0]    opA;
  logic [`EXEC_DATA_W-1:0]    opB;
  logic [`EXEC_DATA_W-1:0]    imm;
  logic [`EXEC_DATA_W-1:0]    pcEx;
  aluPkg::aluOpE              aluOp;
  logic                       aluSrc;
  logic                       invA;
  logic                       invB;
  logic                       cin;
  logic                       sign;
  aluPkg::passSelE            passSel;
  logic                       decWrEn;
  logic [`EXEC_REG_IDX_W-1:0] dest;

  // Write-back
  logic                       rfWrEn;
  logic [`EXEC_REG_IDX_W-1:0] rfWrAddr;
  logic [`EXEC_DATA_W-1:0]    rfWrData;

  regFile uRegFile (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (rfWrEn),
    .wrAddr  (rfWrAddr),
    .wrData  (rfWrData)
  );

  instrDecode uDecode (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .pc         (pc),
    .rdAddrA    (rdAddrA),
    .rdAddrB    (rdAddrB),
    .rdDataA    (rdDataA),
    .rdDataB    (rdDataB),
    .exValid    (exValid),
    .opA        (opA),
    .opB        (opB),
    .imm        (imm),
    .pcOut      (pcEx),
    .aluOp      (aluOp),
    .aluSrc     (aluSrc),
    .invA       (invA),
    .invB       (invB),
    .cin        (cin),
    .sign       (sign),
    .passSel    (passSel),
    .wrEn       (decWrEn),
    .dest       (dest)
  );

  executeStage uExecute (
    .clk          (clk),
    .rstN         (rstN),
    .exValid      (exValid),
    .opA          (opA),
    .opB          (opB),
    .imm          (imm),
    .pc           (pcEx),
    .aluOp        (aluOp),
    .aluSrc       (aluSrc),
    .invA         (invA),
    .invB         (invB),
    .cin          (cin),
    .sign         (sign),
    .passSel      (passSel),
    .wrReq        (decWrEn),
    .dest         (dest),
    .resValid     (resValid),
    .aluResult    (aluResult),
    .branchTarget (branchTarget),
    .resDest      (resDest),
    .zero         (zero),
    .ltz          (ltz),
    .err          (err),
    .wrEn         (rfWrEn),
    .wrAddr       (rfWrAddr),
    .wrData       (rfWrData)
  );

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module executeStage (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       exValid,
  input  logic [`EXEC_DATA_W-1:0]    opA,
  input  logic [`EXEC_DATA_W-1:0]    opB,
  input  logic [`EXEC_DATA_W-1:0]    imm,
  input  logic [`EXEC_DATA_W-1:0]    pc,
  input  aluPkg::aluOpE              aluOp,
  input  logic                       aluSrc,
  input  logic                       invA,
  input  logic                       invB,
  input  logic                       cin,
  input  logic                       sign,
  input  aluPkg::passSelE            passSel,
  input  logic                       wrReq, // Decoded write enable
  input  logic [`EXEC_REG_IDX_W-1:0] dest,
  output logic                       resValid,
  output logic [`EXEC_DATA_W-1:0]    aluResult,
  output logic [`EXEC_DATA_W-1:0]    branchTarget,
  output logic [`EXEC_REG_IDX_W-1:0] resDest,
  output logic                       zero,
  output logic                       ltz,
  output logic                       err,
  output logic                       wrEn,
  output logic [`EXEC_REG_IDX_W-1:0] wrAddr,
  output logic [`EXEC_DATA_W-1:0]    wrData
);

  logic [`EXEC_DATA_W-1:0] aluB;
  logic [`EXEC_DATA_W-1:0] aluOut;
  logic [`EXEC_DATA_W-1:0] passOut;
  logic [`EXEC_DATA_W-1:0] brSum;
  logic                    aluOfl;
  logic                    aluZero;
  logic                    aluLtz;
  logic                    brCarry;
  logic                    errNext;

  assign aluB = aluSrc ? imm : opB; // Register or immediate

  aluCore uAlu (
    .a      (opA),
    .b      (aluB),
    .cin    (cin),
    .invA   (invA),
    .invB   (invB),
    .sign   (sign),
    .aluOp  (aluOp),
    .result (aluOut),
    .ofl    (aluOfl),
    .zero   (aluZero),
    .ltz    (aluLtz)
  );

  always_comb begin
    case (passSel)
      aluPkg::passA: passOut = opA;
      aluPkg::passB: passOut = aluB;
      default:       passOut = aluOut;
    endcase
  end

  // Branch target as a plain unsigned add with carry out
  assign {brCarry, brSum} = {1'b0, pc} + {1'b0, imm};

  // Pass-through results never flag an error
  assign errNext = (aluOfl | brCarry) & (passSel == aluPkg::passNone);

  // Write-back lands on the same edge that registers the result
  assign wrEn   = exValid & wrReq;
  assign wrAddr = dest;
  assign wrData = passOut;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else begin
      resValid <= exValid;
    end
  end

  // Results hold until the next valid instruction
  always_ff @(posedge clk) begin
    if (exValid) begin
      aluResult    <= passOut;
      branchTarget <= brSum;
      resDest      <= dest;
      zero         <= aluZero;
      ltz          <= aluLtz;
      err          <= errNext;
    end
  end

  // Results come out one cycle after exValid and carry no unknown bits
  resValidResultsKnown: assert property (@(posedge clk) disable iff (!rstN)
    exValid |=> resValid && !$isunknown({aluResult, branchTarget, resDest, zero, ltz, err}))
    else $error("resValid missing or results unknown one cycle after exValid");

endmodule

`default_nettype wire

// ==== hw/aluCore.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module aluCore (
  input  logic [`EXEC_DATA_W-1:0] a,
  input  logic [`EXEC_DATA_W-1:0] b,
  input  logic                    cin,
  input  logic                    invA,
  input  logic                    invB,
  input  logic                    sign, // Overflow rule, signed or unsigned
  input  aluPkg::aluOpE           aluOp,
  output logic [`EXEC_DATA_W-1:0] result,
  output logic                    ofl,
  output logic                    zero,
  output logic                    ltz
);

  localparam int shW = $clog2(`EXEC_DATA_W); // 4 bits of shift count

  logic [`EXEC_DATA_W-1:0] aIn;
  logic [`EXEC_DATA_W-1:0] bIn;
  logic [`EXEC_DATA_W-1:0] sum;
  logic                    carry;
  logic                    sOfl;

  // Optional inversion ahead of every operation
  assign aIn = invA ? ~a : a;
  assign bIn = invB ? ~b : b;

  // One adder serves add and subtract
  assign {carry, sum} = {1'b0, aIn} + {1'b0, bIn} + {{`EXEC_DATA_W{1'b0}}, cin};

  // Same-sign inputs giving a different-sign sum
  assign sOfl = (aIn[`EXEC_DATA_W-1] == bIn[`EXEC_DATA_W-1]) &&
                (sum[`EXEC_DATA_W-1] != aIn[`EXEC_DATA_W-1]);

  always_comb begin
    case (aluOp)
      aluPkg::aluAdd: result = sum;
      aluPkg::aluAnd: result = aIn & bIn;
      aluPkg::aluOr:  result = aIn | bIn;
      aluPkg::aluXor: result = aIn ^ bIn;
      aluPkg::aluShl: result = aIn << bIn[shW-1:0];
      aluPkg::aluShr: result = aIn >> bIn[shW-1:0]; // Zero fill
      default:        result = sum;
    endcase
  end

  // Only the adder can overflow
  // unsigned mode reports the carry out instead
  always_comb begin
    if (aluOp == aluPkg::aluAdd) begin
      ofl = sign ? sOfl : carry;
    end else begin
      ofl = 1'b0;
    end
  end

  assign zero = (result == '0);
  assign ltz  = result[`EXEC_DATA_W-1]; // MSB as sign

endmodule

`default_nettype wire

// ==== hw/instrDecode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module instrDecode (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       instrValid,
  input  logic [`EXEC_DATA_W-1:0]    instr,
  input  logic [`EXEC_DATA_W-1:0]    pc,
  output logic [`EXEC_REG_IDX_W-1:0] rdAddrA,
  output logic [`EXEC_REG_IDX_W-1:0] rdAddrB,
  input  logic [`EXEC_DATA_W-1:0]    rdDataA,
  input  logic [`EXEC_DATA_W-1:0]    rdDataB,
  output logic                       exValid,
  output logic [`EXEC_DATA_W-1:0]    opA,
  output logic [`EXEC_DATA_W-1:0]    opB,
  output logic [`EXEC_DATA_W-1:0]    imm,
  output logic [`EXEC_DATA_W-1:0]    pcOut,
  output aluPkg::aluOpE              aluOp,
  output logic                       aluSrc, // 1 selects imm as operand B
  output logic                       invA,
  output logic                       invB,
  output logic                       cin,
  output logic                       sign,
  output aluPkg::passSelE            passSel,
  output logic                       wrEn,
  output logic [`EXEC_REG_IDX_W-1:0] dest
);

  isaPkg::opcodeE          opc;
  logic [`EXEC_DATA_W-1:0] immExt;
  aluPkg::aluOpE           aluOpNext;
  aluPkg::passSelE         passSelNext;
  logic                    aluSrcNext;
  logic                    invANext;
  logic                    invBNext;
  logic                    cinNext;
  logic                    signNext;
  logic                    wrEnNext;
  logic                    zeroB; // Branch compares rs against zero

  assign opc = isaPkg::opcodeE'(instr[isaPkg::opcodeMsb:isaPkg::opcodeLsb]);
  assign rdAddrA = instr[isaPkg::rsMsb:isaPkg::rsLsb]; // Register reads are combinational
  assign rdAddrB = instr[isaPkg::rtMsb:isaPkg::rtLsb];

  // Sign extend imm6 to the datapath width
  assign immExt = {{(`EXEC_DATA_W - isaPkg::immMsb - 1){instr[isaPkg::immMsb]}},
                   instr[isaPkg::immMsb:isaPkg::immLsb]};

  always_comb begin
    aluOpNext   = aluPkg::aluAdd;
    passSelNext = aluPkg::passNone;
    aluSrcNext  = 1'b0;
    invANext    = 1'b0;
    invBNext    = 1'b0;
    cinNext     = 1'b0;
    signNext    = 1'b0;
    wrEnNext    = 1'b1; // Most opcodes write rd
    zeroB       = 1'b0;
    case (opc)
      isaPkg::opAdd:   signNext = 1'b1;
      isaPkg::opSub: begin
        invBNext = 1'b1; // rs + ~rt + 1
        cinNext  = 1'b1;
        signNext = 1'b1;
      end
      isaPkg::opAnd:   aluOpNext = aluPkg::aluAnd;
      isaPkg::opOr:    aluOpNext = aluPkg::aluOr;
      isaPkg::opXor:   aluOpNext = aluPkg::aluXor;
      isaPkg::opShl:   aluOpNext = aluPkg::aluShl;
      isaPkg::opShr:   aluOpNext = aluPkg::aluShr;
      isaPkg::opAddi: begin
        aluSrcNext = 1'b1;
        signNext   = 1'b1;
      end
      isaPkg::opAndni: begin
        aluOpNext  = aluPkg::aluAnd;
        aluSrcNext = 1'b1;
        invBNext   = 1'b1; // AND with inverted immediate
      end
      isaPkg::opLbi: begin
        aluSrcNext  = 1'b1;
        passSelNext = aluPkg::passB; // Immediate straight through
      end
      isaPkg::opMov: begin
        passSelNext = aluPkg::passA;
        wrEnNext    = 1'b0;
      end
      isaPkg::opBr: begin
        zeroB    = 1'b1; // rs + 0 drives zero and ltz
        wrEnNext = 1'b0;
      end
      default:         wrEnNext = 1'b0; // Unused encodings do nothing
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
      wrEn    <= 1'b0;
    end else begin
      exValid <= instrValid; // One-cycle strobe into execute
      if (instrValid) begin
        wrEn <= wrEnNext;
      end
    end
  end

  // Operands and controls captured only for a valid instruction
  always_ff @(posedge clk) begin
    if (instrValid) begin
      opA     <= rdDataA;
      opB     <= zeroB ? '0 : rdDataB;
      imm     <= immExt;
      pcOut   <= pc;
      aluOp   <= aluOpNext;
      aluSrc  <= aluSrcNext;
      invA    <= invANext;
      invB    <= invBNext;
      cin     <= cinNext;
      sign    <= signNext;
      passSel <= passSelNext;
      dest    <= instr[isaPkg::rdMsb:isaPkg::rdLsb];
    end
  end

  // A valid instruction reaches execute next cycle with known operands
  exValidOperandsKnown: assert property (@(posedge clk) disable iff (!rstN)
    instrValid |=> exValid && !$isunknown({opA, opB, imm, pcOut}))
    else $error("exValid missing or operands unknown after instrValid");

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "execUnit_macros.svh"

module regFile (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [`EXEC_REG_IDX_W-1:0] rdAddrA,
  input  logic [`EXEC_REG_IDX_W-1:0] rdAddrB,
  output logic [`EXEC_DATA_W-1:0]    rdDataA,
  output logic [`EXEC_DATA_W-1:0]    rdDataB,
  input  logic                       wrEn,
  input  logic [`EXEC_REG_IDX_W-1:0] wrAddr,
  input  logic [`EXEC_DATA_W-1:0]    wrData
);

  logic [`EXEC_DATA_W-1:0] regs [`EXEC_NUM_REGS];

  // Single write port, committed on the edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `EXEC_NUM_REGS; i++) begin
        regs[i] <= '0; // All registers read zero after reset
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through so a dependent instruction in decode
  // sees the value that execute is writing this cycle
  assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

  // Unknown write index would corrupt an arbitrary entry
  wrAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
    wrEn |-> !$isunknown(wrAddr))
    else $error("regFile write with unknown address");

endmodule

`default_nettype wire

// ==== hw/aluPkg.sv ====
`default_nettype none

package aluPkg;

  // Operations the ALU core understands
  // Subtract is aluAdd with invB and cin set
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluAnd = 3'd1,
    aluOr  = 3'd2,
    aluXor = 3'd3,
    aluShl = 3'd4,
    aluShr = 3'd5
  } aluOpE;

  // Result source after the ALU
  typedef enum logic [1:0] {
    passNone = 2'd0, // ALU output
    passA    = 2'd1, // rs data as read
    passB    = 2'd2  // Selected second operand
  } passSelE;

endpackage

`default_nettype wire

// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Major opcode held in the top nibble of the instruction
  typedef enum logic [3:0] {
    opAdd   = 4'h0, // rd = rs + rt
    opSub   = 4'h1, // rd = rs - rt
    opAnd   = 4'h2,
    opOr    = 4'h3,
    opXor   = 4'h4,
    opShl   = 4'h5, // Shift count from rt[3:0]
    opShr   = 4'h6, // Logical, zero fill
    opAddi  = 4'h7, // rd = rs + simm6
    opAndni = 4'h8, // rd = rs & ~simm6
    opLbi   = 4'h9, // rd = simm6
    opMov   = 4'ha, // Result only, rd not written
    opBr    = 4'hb  // Target pc + simm6, flags of rs
  } opcodeE;

  // Field positions in the 16-bit word
  localparam int opcodeMsb = 15;
  localparam int opcodeLsb = 12;
  localparam int rdMsb     = 11; // Destination
  localparam int rdLsb     = 9;
  localparam int rsMsb     = 8;  // First source
  localparam int rsLsb     = 6;
  localparam int rtMsb     = 5;  // Second source, overlaps imm
  localparam int rtLsb     = 3;

  // Immediate sits in the low bits and is sign extended
  localparam int immMsb    = 5;
  localparam int immLsb    = 0;

endpackage

`default_nettype wire

// ==== hw/execUnit_macros.svh ====
`ifndef EXEC_UNIT_MACROS_SVH
`define EXEC_UNIT_MACROS_SVH

// Datapath width, shared by operands, results and pc
`define EXEC_DATA_W 16

// Architectural registers r0..r7
`define EXEC_NUM_REGS 8

// Bits needed to name one register
`define EXEC_REG_IDX_W 3

// Keep EXEC_NUM_REGS == 2**EXEC_REG_IDX_W
// or the decoder can address a missing entry

`endif
